//--- bench/noc_read_adapter_asserts.sv
`timescale 1ns/1ps

module noc_read_adapter_asserts (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_wr,
  input logic                     i_pop,
  input logic                     i_arvalid,
  input logic                     i_arready,
  input logic                     i_rvalid,
  input logic                     i_rready,
  input logic                     i_rlast,
  input logic [31:0]              i_rdata,
  input logic [3:0]               i_rid,
  input axi_read_pkg::axi_resp_e  i_rresp
);

  logic [noc_packet_pkg::FIFO_PTR_WIDTH:0] fill;
  logic                                    outstanding;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fill        <= '0;
      outstanding <= 1'b0;
    end else begin
      fill <= fill + (i_wr ? 1'b1 : 1'b0) - (i_pop ? 1'b1 : 1'b0);
      if (i_arvalid && i_arready) outstanding <= 1'b1;
      else if (i_rvalid && i_rready && i_rlast) outstanding <= 1'b0;
    end
  end

  no_write_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (fill == noc_packet_pkg::FIFO_DEPTH) |-> !i_wr)
    else $error("flit written into a full FIFO");

  no_pop_when_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> (fill != '0))
    else $error("pop from an empty FIFO");

  r_stable_while_stalled: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata) && $stable(i_rid) &&
                                 $stable(i_rresp) && $stable(i_rlast)))
    else $error("R beat changed while stalled");

  arready_low_in_burst: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    outstanding |-> !i_arready)
    else $error("arready high with a read outstanding");

endmodule

bind noc_read_adapter noc_read_adapter_asserts adapter_asserts_inst (
  .i_clk     (i_clk),
  .i_rst_n   (i_rst_n),
  .i_wr      (i_rsp_valid),
  .i_pop     (pop),
  .i_arvalid (i_arvalid),
  .i_arready (o_arready),
  .i_rvalid  (o_rvalid),
  .i_rready  (i_rready),
  .i_rlast   (o_rlast),
  .i_rdata   (o_rdata),
  .i_rid     (o_rid),
  .i_rresp   (o_rresp)
);

//--- bench/read_stim.txt
// columns: araddr arlen arsize arid status exp_beats exp_rresp stall
// status and rresp use 0 okay, 2 slverr, 3 decerr; last line ends the list
00001000 3 2 1 0 04 0 0
00006004 f 2 2 0 10 0 1
00002001 5 0 3 0 06 0 0
00003003 6 1 4 0 07 0 1
0000c000 7 2 5 2 08 2 1
00010000 1 2 6 0 02 3 0
0000f006 9 1 7 0 0a 0 1
00004000 0 2 8 0 01 0 0
00005007 f 0 9 2 10 2 1
00009000 f 2 f 0 10 0 0
ffffffff 0 0 0 0 00 0 0

//--- bench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic [1:0]                  i_id_x,
  input  logic [1:0]                  i_id_y,
  input  logic                        i_arvalid,
  input  logic [31:0]                 i_araddr,
  input  logic [3:0]                  i_arlen,
  input  logic [2:0]                  i_arsize,
  input  logic [3:0]                  i_arid,
  input  logic                        i_arready,
  input  logic                        i_req_valid,
  input  logic [63:0]                 i_req_data,
  input  logic                        i_rsp_valid,
  input  noc_packet_pkg::flit_kind_e  i_rsp_kind,
  input  logic [63:0]                 i_rsp_data,
  input  logic                        i_rvalid,
  input  logic [31:0]                 i_rdata,
  input  logic [3:0]                  i_rid,
  input  axi_read_pkg::axi_resp_e     i_rresp,
  input  logic                        i_rlast,
  input  logic                        i_rready,
  input  logic [7:0]                  i_exp_beats,
  input  logic [1:0]                  i_exp_resp,
  output int                          o_tests_passed,
  output int                          o_tests_failed,
  output int                          o_error_count
);

  logic [63:0] word_q[$];  // payload words seen on the network side
  logic [63:0] exp_req;
  logic [3:0]  cur_id;
  logic [2:0]  pos;
  logic        req_pending;
  logic        ready_check;
  int          step;
  int          beat_cnt;
  int          test_num;
  int          test_errs;

  function automatic logic [63:0] expected_request(input logic [31:0] addr,
      input logic [3:0] len, input logic [2:0] size, input logic [3:0] id,
      input logic [1:0] sx, input logic [1:0] sy);
    logic [63:0] h;
    int mask;
    int bytes;
    mask  = (1 << size) - 1;
    bytes = ((int'(len) + 1) << size) - (int'(addr[6:0]) & mask);
    if (bytes > 64) bytes = 64;
    h = '0;
    h[noc_packet_pkg::PKT_TYPE_LSB +: 2] = noc_packet_pkg::PKT_READ;
    h[noc_packet_pkg::DEST_X_LSB +: 2]   = addr[13:12];
    h[noc_packet_pkg::DEST_Y_LSB +: 2]   = addr[15:14];
    h[noc_packet_pkg::SRC_X_LSB +: 2]    = sx;
    h[noc_packet_pkg::SRC_Y_LSB +: 2]    = sy;
    h[noc_packet_pkg::INVALID_BIT]       = |addr[31:16];
    h[noc_packet_pkg::TAG_LSB +: 4]      = id;
    h[noc_packet_pkg::SIZE_LSB +: 3]     = size;
    h[noc_packet_pkg::LENGTH_LSB +: 7]   = 7'(bytes);
    h[noc_packet_pkg::ADDR_LSB +: 32]    = addr & ~32'(mask);
    return h;
  endfunction

  task automatic value_fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    o_error_count++;
    test_errs++;
  endtask

  task automatic protocol_fail(input string msg);
    $display("Error at %0t: %s", $time, msg);
    o_error_count++;
    test_errs++;
  endtask

  always @(posedge i_clk) begin
    logic [63:0] word;
    logic [31:0] exp_data;
    int next_pos;
    if (!i_rst_n) begin
      o_tests_passed = 0;
      o_tests_failed = 0;
      o_error_count  = 0;
      req_pending    = 1'b0;
      ready_check    = 1'b0;
      test_num       = 0;
    end else begin
      if (ready_check) begin
        ready_check = 1'b0;
        if (!i_arready) protocol_fail("arready did not come back after the final beat");
      end
      if (req_pending) begin
        req_pending = 1'b0;
        if (!i_req_valid) protocol_fail("no request flit in the cycle after the AR handshake");
        else if (i_req_data !== exp_req)
          value_fail($sformatf("request flit %h, expected %h", i_req_data, exp_req));
      end else if (i_req_valid) begin
        protocol_fail("request strobe without an AR handshake");
      end
      if (i_arvalid && i_arready) begin
        exp_req     = expected_request(i_araddr, i_arlen, i_arsize, i_arid, i_id_x, i_id_y);
        req_pending = 1'b1;
        step        = 1 << ((i_arsize > 3'd2) ? 2 : int'(i_arsize));
        pos         = i_araddr[2:0] & ~3'(step - 1);  // first beat lane from the aligned address
        cur_id      = i_arid;
        beat_cnt    = 0;
        test_errs   = 0;
        test_num++;
      end
      if (i_rvalid && i_rready) begin
        beat_cnt++;
        if (word_q.size() == 0) begin
          protocol_fail("R beat with no payload flit sent");
        end else begin
          word     = word_q[0];
          exp_data = pos[2] ? word[63:32] : word[31:0];
          if (i_rdata !== exp_data)
            value_fail($sformatf("beat %0d rdata %h, expected %h", beat_cnt, i_rdata, exp_data));
          next_pos = int'(pos) + step;
          if (next_pos >= 8 || i_rlast) void'(word_q.pop_front());
          pos = 3'(next_pos);
        end
        if (i_rid !== cur_id) value_fail($sformatf("rid %h, expected %h", i_rid, cur_id));
        if (i_rresp !== i_exp_resp)
          value_fail($sformatf("rresp %0d, expected %0d", i_rresp, i_exp_resp));
        if (i_rlast) begin
          if (beat_cnt != int'(i_exp_beats))
            value_fail($sformatf("burst of %0d beats, expected %0d", beat_cnt, i_exp_beats));
          if (word_q.size() != 0) protocol_fail("payload flits left over after rlast");
          ready_check = 1'b1;
          if (test_errs == 0) begin
            o_tests_passed++;
            $display("test %0d (id %h): %0d beats ok", test_num, cur_id, beat_cnt);
          end else begin
            o_tests_failed++;
            $display("test %0d (id %h): %0d errors", test_num, cur_id, test_errs);
          end
        end else if (beat_cnt >= int'(i_exp_beats)) begin
          value_fail($sformatf("no rlast on beat %0d", beat_cnt));
        end
      end
      if (i_rsp_valid && i_rsp_kind == noc_packet_pkg::FLIT_PAYLOAD) word_q.push_back(i_rsp_data);
    end
  end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk   = 1'b0;
    o_rst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;  // released away from the active edge
  end

  always #4 o_clk = ~o_clk;  // 8 ns period

endmodule

//--- bench/tb_noc_read_adapter.sv
`timescale 1ns/1ps

module tb_noc_read_adapter;

  localparam int CLK_PERIOD = 8;
  localparam int FIELDS     = 8;

  logic                       clk;
  logic                       rst_n;
  logic [1:0]                 id_x;
  logic [1:0]                 id_y;
  logic                       arvalid;
  logic [31:0]                araddr;
  logic [3:0]                 arlen;
  logic [2:0]                 arsize;
  logic [1:0]                 arburst;
  logic [3:0]                 arid;
  logic                       rsp_valid;
  noc_packet_pkg::flit_kind_e rsp_kind;
  logic [63:0]                rsp_data;
  logic                       rsp_last;
  logic                       rready;
  logic                       arready;
  logic                       req_valid;
  logic [63:0]                req_data;
  logic                       rvalid;
  logic [31:0]                rdata;
  logic [3:0]                 rid;
  axi_read_pkg::axi_resp_e    rresp;
  logic                       rlast;
  logic [7:0]                 exp_beats;
  logic [1:0]                 exp_resp;
  logic                       stall_on;
  logic                       stim_loaded;
  logic [31:0]                stim_mem [0:255];
  int                         num_tests;
  int                         data_seed;
  int                         stall_seed;
  int                         tests_passed;
  int                         tests_failed;
  int                         error_count;

  tb_clock_gen clock_gen_inst (.o_clk(clk), .o_rst_n(rst_n));

  noc_read_adapter noc_read_adapter_inst (
    .i_clk(clk), .i_rst_n(rst_n), .i_id_x(id_x), .i_id_y(id_y),
    .i_arvalid(arvalid), .i_araddr(araddr), .i_arlen(arlen), .i_arsize(arsize),
    .i_arburst(arburst), .i_arid(arid), .i_rsp_valid(rsp_valid), .i_rsp_kind(rsp_kind),
    .i_rsp_data(rsp_data), .i_rsp_last(rsp_last), .i_rready(rready),
    .o_arready(arready), .o_req_valid(req_valid), .o_req_data(req_data),
    .o_rvalid(rvalid), .o_rdata(rdata), .o_rid(rid), .o_rresp(rresp), .o_rlast(rlast)
  );

  tb_checker checker_inst (
    .i_clk(clk), .i_rst_n(rst_n), .i_id_x(id_x), .i_id_y(id_y),
    .i_arvalid(arvalid), .i_araddr(araddr), .i_arlen(arlen), .i_arsize(arsize),
    .i_arid(arid), .i_arready(arready), .i_req_valid(req_valid), .i_req_data(req_data),
    .i_rsp_valid(rsp_valid), .i_rsp_kind(rsp_kind), .i_rsp_data(rsp_data),
    .i_rvalid(rvalid), .i_rdata(rdata), .i_rid(rid), .i_rresp(rresp), .i_rlast(rlast),
    .i_rready(rready), .i_exp_beats(exp_beats), .i_exp_resp(exp_resp),
    .o_tests_passed(tests_passed), .o_tests_failed(tests_failed),
    .o_error_count(error_count)
  );

  // the remote node sends the header first and then enough payload flits to cover the bytes
  task automatic send_response(input logic [63:0] req, input logic [1:0] status);
    logic [63:0] hdr;
    logic [31:0] lo;
    logic [31:0] hi;
    int size;
    int step;
    int len;
    int off;
    int flits;
    size  = int'(req[noc_packet_pkg::SIZE_LSB +: 3]);
    if (size > 2) size = 2;
    step  = 1 << size;
    len   = int'(req[noc_packet_pkg::LENGTH_LSB +: 7]);
    off   = int'(req[noc_packet_pkg::ADDR_LSB +: 3]);
    flits = (off + ((len + step - 1) / step) * step + 7) / 8;
    hdr = req;
    hdr[63:32] = '0;
    hdr[noc_packet_pkg::PKT_TYPE_LSB +: 2] = noc_packet_pkg::PKT_RESPONSE;
    hdr[noc_packet_pkg::DEST_X_LSB +: 4]   = req[noc_packet_pkg::SRC_X_LSB +: 4];
    hdr[noc_packet_pkg::SRC_X_LSB +: 4]    = req[noc_packet_pkg::DEST_X_LSB +: 4];
    hdr[noc_packet_pkg::OFFSET_LSB +: 3]   = 3'(off);
    hdr[noc_packet_pkg::STATUS_LSB +: 2]   = req[noc_packet_pkg::INVALID_BIT] ? 2'b11 : status;
    repeat (3) @(negedge clk);
    for (int i = 0; i <= flits; i++) begin
      @(negedge clk);
      rsp_valid = 1'b1;
      rsp_last  = (i == flits);
      if (i == 0) begin
        rsp_kind = noc_packet_pkg::FLIT_HEADER;
        rsp_data = hdr;
      end else begin
        lo = $random(data_seed);
        hi = $random(data_seed);
        rsp_kind = noc_packet_pkg::FLIT_PAYLOAD;
        rsp_data = {hi, lo};
      end
    end
    @(negedge clk);
    rsp_valid = 1'b0;
    rsp_last  = 1'b0;
  endtask

  task automatic run_test(input int t);
    logic [63:0] req;
    int b;
    b = t * FIELDS;
    @(negedge clk);
    araddr    = stim_mem[b];
    arlen     = 4'(stim_mem[b + 1]);
    arsize    = 3'(stim_mem[b + 2]);
    arid      = 4'(stim_mem[b + 3]);
    exp_beats = 8'(stim_mem[b + 5]);
    exp_resp  = 2'(stim_mem[b + 6]);
    stall_on  = stim_mem[b + 7][0];
    arvalid   = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!req_valid) @(negedge clk);
    req = req_data;
    send_response(req, 2'(stim_mem[b + 4]));
    do @(negedge clk); while (!arready);  // arready comes back after the final beat
  endtask

  always @(negedge clk) begin
    int r;
    if (stall_on) begin
      r = $random(stall_seed);
      rready = (r[1:0] != 2'b00);
    end else begin
      rready = 1'b1;
    end
  end

  initial begin
    data_seed   = 18950;
    stall_seed  = 18950;
    stim_loaded = 1'b0;
    id_x = 2'd1;
    id_y = 2'd2;
    arvalid = 1'b0;
    araddr = '0;
    arlen = '0;
    arsize = '0;
    arburst = 2'b01;
    arid = '0;
    rsp_valid = 1'b0;
    rsp_kind = noc_packet_pkg::FLIT_HEADER;
    rsp_data = '0;
    rsp_last = 1'b0;
    rready = 1'b1;
    exp_beats = '0;
    exp_resp = '0;
    stall_on = 1'b0;
    for (int i = 0; i < 256; i++) stim_mem[i] = '1;
    $readmemh("bench/read_stim.txt", stim_mem);
    num_tests = 0;
    while (num_tests < 32 && stim_mem[num_tests * FIELDS] != 32'hffff_ffff) num_tests++;
    stim_loaded = 1'b1;
    wait (rst_n);
    for (int t = 0; t < num_tests; t++) run_test(t);
    repeat (4) @(negedge clk);
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             num_tests, tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0 && tests_passed == num_tests) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    wait (stim_loaded);
    #(num_tests * 200 * CLK_PERIOD + 20 * CLK_PERIOD);
    $display("timeout: the tests did not finish in %0d cycles", num_tests * 200 + 20);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- hdl/axi_read_pkg.sv
package axi_read_pkg;

  localparam int AXI_DATA_WIDTH = 32;
  localparam int AXI_ADDR_WIDTH = 32;
  localparam int AXI_ID_WIDTH   = 4;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic [2:0] {
    SIZE_1B = 3'd0,
    SIZE_2B = 3'd1,
    SIZE_4B = 3'd2
  } axi_size_e;

  localparam int MAX_AXI_SIZE = 2;  // the R data bus carries 4 bytes

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01
  } axi_burst_e;

endpackage

//--- hdl/noc_packet_pkg.sv
package noc_packet_pkg;

  localparam int FLIT_WIDTH    = 64;
  localparam int NODE_ID_WIDTH = 2;

  typedef enum logic {
    FLIT_HEADER  = 1'b0,
    FLIT_PAYLOAD = 1'b1
  } flit_kind_e;

  typedef enum logic [1:0] {
    PKT_READ     = 2'd0,
    PKT_RESPONSE = 2'd1
  } packet_type_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // header flit layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int PKT_TYPE_LSB   = 0;
  localparam int PKT_TYPE_WIDTH = 2;
  localparam int DEST_X_LSB     = 2;
  localparam int DEST_Y_LSB     = 4;
  localparam int SRC_X_LSB      = 6;
  localparam int SRC_Y_LSB      = 8;
  localparam int INVALID_BIT    = 10;
  localparam int TAG_LSB        = 11;
  localparam int TAG_WIDTH      = 4;
  localparam int SIZE_LSB       = 15;
  localparam int SIZE_WIDTH     = 3;
  localparam int LENGTH_LSB     = 18;
  localparam int LENGTH_WIDTH   = 7;
  localparam int OFFSET_LSB     = 25;  // response header only
  localparam int OFFSET_WIDTH   = 3;
  localparam int STATUS_LSB     = 28;  // response header only
  localparam int STATUS_WIDTH   = 2;
  localparam int ADDR_LSB       = 32;  // request header only
  localparam int ADDR_WIDTH     = 32;

  localparam int MAX_BYTE_LENGTH = 64;  // 16 beats of 4 bytes

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // node address map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NODE_X_ADDR_LSB = 12;
  localparam int NODE_Y_ADDR_LSB = 14;
  localparam int NODE_SPACE_LSB  = 16;  // anything set from here up hits no node

  localparam int FIFO_DEPTH     = 16;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

endpackage

//--- hdl/noc_read_adapter.sv
`timescale 1ns/1ps

module noc_read_adapter (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic [noc_packet_pkg::NODE_ID_WIDTH-1:0]  i_id_x,
  input  logic [noc_packet_pkg::NODE_ID_WIDTH-1:0]  i_id_y,
  input  logic                                      i_arvalid,
  input  logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0]   i_araddr,
  input  logic [3:0]                                i_arlen,
  input  logic [2:0]                                i_arsize,
  input  logic [1:0]                                i_arburst,
  input  logic [axi_read_pkg::AXI_ID_WIDTH-1:0]     i_arid,
  input  logic                                      i_rsp_valid,
  input  noc_packet_pkg::flit_kind_e                i_rsp_kind,
  input  logic [noc_packet_pkg::FLIT_WIDTH-1:0]     i_rsp_data,
  input  logic                                      i_rsp_last,
  input  logic                                      i_rready,
  output logic                                      o_arready,
  output logic                                      o_req_valid,
  output logic [noc_packet_pkg::FLIT_WIDTH-1:0]     o_req_data,
  output logic                                      o_rvalid,
  output logic [axi_read_pkg::AXI_DATA_WIDTH-1:0]   o_rdata,
  output logic [axi_read_pkg::AXI_ID_WIDTH-1:0]     o_rid,
  output axi_read_pkg::axi_resp_e                   o_rresp,
  output logic                                      o_rlast
);

  logic                                   fifo_empty;
  noc_packet_pkg::flit_kind_e             head_kind;
  logic [noc_packet_pkg::FLIT_WIDTH-1:0]  head_data;
  logic                                   head_last;
  logic                                   pop;
  logic                                   burst_done;  // frees the AR side for the next read

  read_request_packer request_packer_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_id_x       (i_id_x),
    .i_id_y       (i_id_y),
    .i_arvalid    (i_arvalid),
    .i_araddr     (i_araddr),
    .i_arlen      (i_arlen),
    .i_arsize     (i_arsize),
    .i_arburst    (i_arburst),
    .i_arid       (i_arid),
    .i_burst_done (burst_done),
    .o_arready    (o_arready),
    .o_req_valid  (o_req_valid),
    .o_req_data   (o_req_data)
  );

  response_flit_fifo flit_fifo_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wr        (i_rsp_valid),
    .i_wr_kind   (i_rsp_kind),
    .i_wr_data   (i_rsp_data),
    .i_wr_last   (i_rsp_last),
    .i_pop       (pop),
    .o_empty     (fifo_empty),
    .o_head_kind (head_kind),
    .o_head_data (head_data),
    .o_head_last (head_last)
  );

  read_response_unpacker response_unpacker_inst (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_empty      (fifo_empty),
    .i_head_kind  (head_kind),
    .i_head_data  (head_data),
    .i_head_last  (head_last),
    .i_rready     (i_rready),
    .o_pop        (pop),
    .o_rvalid     (o_rvalid),
    .o_rdata      (o_rdata),
    .o_rid        (o_rid),
    .o_rresp      (o_rresp),
    .o_rlast      (o_rlast),
    .o_burst_done (burst_done)
  );

endmodule

//--- hdl/read_request_packer.sv
`timescale 1ns/1ps

module read_request_packer (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic [noc_packet_pkg::NODE_ID_WIDTH-1:0]  i_id_x,
  input  logic [noc_packet_pkg::NODE_ID_WIDTH-1:0]  i_id_y,
  input  logic                                      i_arvalid,
  input  logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0]   i_araddr,
  input  logic [3:0]                                i_arlen,
  input  logic [2:0]                                i_arsize,
  input  logic [1:0]                                i_arburst,
  input  logic [axi_read_pkg::AXI_ID_WIDTH-1:0]     i_arid,
  input  logic                                      i_burst_done,
  output logic                                      o_arready,
  output logic                                      o_req_valid,
  output logic [noc_packet_pkg::FLIT_WIDTH-1:0]     o_req_data
);

  typedef enum logic {
    REQ_IDLE,
    REQ_WAIT
  } req_state_e;

  typedef logic [noc_packet_pkg::LENGTH_WIDTH-1:0] length_t;

  req_state_e                                 state;
  logic                                       ar_hs;
  logic                                       node_miss;
  logic                                       burst_bad;
  logic [6:0]                                 size_mask;
  logic [11:0]                                total_bytes;
  logic [11:0]                                req_bytes;
  length_t                                    byte_length;
  logic [axi_read_pkg::AXI_ADDR_WIDTH-1:0]    aligned_addr;
  logic [noc_packet_pkg::FLIT_WIDTH-1:0]      header;

  assign o_arready = (state == REQ_IDLE);  // one read in flight at a time
  assign ar_hs     = i_arvalid && o_arready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // header build
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    node_miss    = |i_araddr[axi_read_pkg::AXI_ADDR_WIDTH-1:noc_packet_pkg::NODE_SPACE_LSB];
    burst_bad    = (i_arburst != axi_read_pkg::BURST_FIXED) &&
                   (i_arburst != axi_read_pkg::BURST_INCR);  // wrap is not carried
    size_mask    = 7'((8'd1 << i_arsize) - 8'd1);
    aligned_addr = {i_araddr[axi_read_pkg::AXI_ADDR_WIDTH-1:7], i_araddr[6:0] & ~size_mask};
    total_bytes  = (12'(i_arlen) + 12'd1) << i_arsize;
    req_bytes    = total_bytes - 12'(i_araddr[6:0] & size_mask);
    byte_length  = (req_bytes > 12'(noc_packet_pkg::MAX_BYTE_LENGTH)) ?
                   length_t'(noc_packet_pkg::MAX_BYTE_LENGTH) : length_t'(req_bytes);

    header = '0;
    header[noc_packet_pkg::PKT_TYPE_LSB +: noc_packet_pkg::PKT_TYPE_WIDTH] =
      noc_packet_pkg::PKT_READ;
    header[noc_packet_pkg::DEST_X_LSB +: noc_packet_pkg::NODE_ID_WIDTH] =
      i_araddr[noc_packet_pkg::NODE_X_ADDR_LSB +: noc_packet_pkg::NODE_ID_WIDTH];
    header[noc_packet_pkg::DEST_Y_LSB +: noc_packet_pkg::NODE_ID_WIDTH] =
      i_araddr[noc_packet_pkg::NODE_Y_ADDR_LSB +: noc_packet_pkg::NODE_ID_WIDTH];
    header[noc_packet_pkg::SRC_X_LSB +: noc_packet_pkg::NODE_ID_WIDTH]   = i_id_x;
    header[noc_packet_pkg::SRC_Y_LSB +: noc_packet_pkg::NODE_ID_WIDTH]   = i_id_y;
    header[noc_packet_pkg::INVALID_BIT]                                   = node_miss || burst_bad;
    header[noc_packet_pkg::TAG_LSB +: noc_packet_pkg::TAG_WIDTH]         = i_arid;
    header[noc_packet_pkg::SIZE_LSB +: noc_packet_pkg::SIZE_WIDTH]       = i_arsize;
    header[noc_packet_pkg::LENGTH_LSB +: noc_packet_pkg::LENGTH_WIDTH]   = byte_length;
    header[noc_packet_pkg::ADDR_LSB +: noc_packet_pkg::ADDR_WIDTH]       = aligned_addr;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state       <= REQ_IDLE;
      o_req_valid <= 1'b0;
    end else begin
      o_req_valid <= ar_hs;  // single strobe, the network never stalls
      case (state)
        REQ_IDLE: if (ar_hs) state <= REQ_WAIT;
        REQ_WAIT: if (i_burst_done) state <= REQ_IDLE;
        default:  state <= REQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (ar_hs) begin
      o_req_data <= header;
    end
  end

endmodule

//--- hdl/read_response_unpacker.sv
`timescale 1ns/1ps

module read_response_unpacker (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic                                      i_empty,
  input  noc_packet_pkg::flit_kind_e                i_head_kind,
  input  logic [noc_packet_pkg::FLIT_WIDTH-1:0]     i_head_data,
  input  logic                                      i_head_last,
  input  logic                                      i_rready,
  output logic                                      o_pop,
  output logic                                      o_rvalid,
  output logic [axi_read_pkg::AXI_DATA_WIDTH-1:0]   o_rdata,
  output logic [axi_read_pkg::AXI_ID_WIDTH-1:0]     o_rid,
  output axi_read_pkg::axi_resp_e                   o_rresp,
  output logic                                      o_rlast,
  output logic                                      o_burst_done
);

  typedef enum logic {
    UNP_HEADER,
    UNP_PAYLOAD
  } unp_state_e;

  unp_state_e                                     state;
  logic [noc_packet_pkg::SIZE_WIDTH-1:0]          size_q;
  logic [noc_packet_pkg::STATUS_WIDTH-1:0]        status_q;
  logic                                           invalid_q;
  logic [noc_packet_pkg::OFFSET_WIDTH-1:0]        byte_cnt;   // byte position inside the flit
  logic [noc_packet_pkg::LENGTH_WIDTH-1:0]        bytes_left;
  axi_read_pkg::axi_size_e                        eff_size;
  axi_read_pkg::axi_resp_e                        hdr_resp;
  logic [3:0]                                     step;
  logic [2:0]                                     step_mask;
  logic [2:0]                                     lane_base;
  logic [3:0]                                     next_sum;
  logic [2:0]                                     beat_bytes;
  logic                                           hdr_take;
  logic                                           beat_ack;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // byte counter arithmetic
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    eff_size = (size_q > 3'(axi_read_pkg::MAX_AXI_SIZE)) ?
               axi_read_pkg::axi_size_e'(axi_read_pkg::MAX_AXI_SIZE) :
               axi_read_pkg::axi_size_e'(size_q);
    case (eff_size)
      axi_read_pkg::SIZE_1B: step = 4'd1;
      axi_read_pkg::SIZE_2B: step = 4'd2;
      default:               step = 4'd4;
    endcase
    step_mask  = 3'(step - 4'd1);
    lane_base  = byte_cnt & ~step_mask;
    next_sum   = {1'b0, lane_base} + step;  // bit 3 set means the flit is used up
    beat_bytes = 3'(step - {1'b0, byte_cnt & step_mask});  // first beat may be short
  end

  always_comb begin
    hdr_resp = axi_read_pkg::axi_resp_e'(status_q);
    if (invalid_q || hdr_resp == axi_read_pkg::RESP_DECERR) begin
      o_rresp = axi_read_pkg::RESP_DECERR;
    end else if (hdr_resp == axi_read_pkg::RESP_SLVERR) begin
      o_rresp = axi_read_pkg::RESP_SLVERR;
    end else begin
      o_rresp = axi_read_pkg::RESP_OKAY;
    end
  end

  assign hdr_take = (state == UNP_HEADER) && !i_empty &&
                    (i_head_kind == noc_packet_pkg::FLIT_HEADER);
  assign o_rvalid = (state == UNP_PAYLOAD) && !i_empty &&
                    (i_head_kind == noc_packet_pkg::FLIT_PAYLOAD);
  assign o_rdata  = byte_cnt[2] ? i_head_data[63:32] : i_head_data[31:0];
  assign o_rlast  = i_head_last && (bytes_left <= 7'(beat_bytes));
  assign beat_ack = o_rvalid && i_rready;
  assign o_burst_done = beat_ack && o_rlast;

  // stray payload flits in front of a header are thrown away
  assign o_pop = ((state == UNP_HEADER) && !i_empty) ||
                 (beat_ack && (next_sum[3] || o_rlast));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= UNP_HEADER;
      byte_cnt   <= '0;
      bytes_left <= '0;
    end else if (hdr_take) begin
      state      <= UNP_PAYLOAD;
      byte_cnt   <= i_head_data[noc_packet_pkg::OFFSET_LSB +: noc_packet_pkg::OFFSET_WIDTH];
      bytes_left <= i_head_data[noc_packet_pkg::LENGTH_LSB +: noc_packet_pkg::LENGTH_WIDTH];
    end else if (beat_ack) begin
      byte_cnt   <= next_sum[2:0];
      bytes_left <= bytes_left - 7'(beat_bytes);
      if (o_rlast) state <= UNP_HEADER;
    end
  end

  always_ff @(posedge i_clk) begin
    if (hdr_take) begin
      o_rid     <= i_head_data[noc_packet_pkg::TAG_LSB +: noc_packet_pkg::TAG_WIDTH];
      size_q    <= i_head_data[noc_packet_pkg::SIZE_LSB +: noc_packet_pkg::SIZE_WIDTH];
      status_q  <= i_head_data[noc_packet_pkg::STATUS_LSB +: noc_packet_pkg::STATUS_WIDTH];
      invalid_q <= i_head_data[noc_packet_pkg::INVALID_BIT];
    end
  end

endmodule

//--- hdl/response_flit_fifo.sv
`timescale 1ns/1ps

module response_flit_fifo (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_wr,
  input  noc_packet_pkg::flit_kind_e            i_wr_kind,
  input  logic [noc_packet_pkg::FLIT_WIDTH-1:0] i_wr_data,
  input  logic                                  i_wr_last,
  input  logic                                  i_pop,
  output logic                                  o_empty,
  output noc_packet_pkg::flit_kind_e            o_head_kind,
  output logic [noc_packet_pkg::FLIT_WIDTH-1:0] o_head_data,
  output logic                                  o_head_last
);

  noc_packet_pkg::flit_kind_e             kind_mem [noc_packet_pkg::FIFO_DEPTH];
  logic [noc_packet_pkg::FLIT_WIDTH-1:0]  data_mem [noc_packet_pkg::FIFO_DEPTH];
  logic                                   last_mem [noc_packet_pkg::FIFO_DEPTH];

  logic [noc_packet_pkg::FIFO_PTR_WIDTH-1:0]  wr_ptr;
  logic [noc_packet_pkg::FIFO_PTR_WIDTH-1:0]  rd_ptr;
  logic [noc_packet_pkg::FIFO_PTR_WIDTH:0]    count;
  logic                                       full;
  logic                                       wr_en;
  logic                                       pop_en;

  assign full    = (count == (noc_packet_pkg::FIFO_PTR_WIDTH + 1)'(noc_packet_pkg::FIFO_DEPTH));
  assign o_empty = (count == '0);
  assign wr_en   = i_wr && !full;  // a flit past full is dropped
  assign pop_en  = i_pop && !o_empty;

  assign o_head_kind = kind_mem[rd_ptr];
  assign o_head_data = data_mem[rd_ptr];
  assign o_head_last = last_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      kind_mem[wr_ptr] <= i_wr_kind;
      data_mem[wr_ptr] <= i_wr_data;
      last_mem[wr_ptr] <= i_wr_last;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap at the depth
      if (pop_en) rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && !pop_en) count <= count + 1'b1;
      else if (pop_en && !wr_en) count <= count - 1'b1;
    end
  end

endmodule

//--- list.f
hdl/noc_packet_pkg.sv
hdl/axi_read_pkg.sv
hdl/read_request_packer.sv
hdl/response_flit_fifo.sv
hdl/read_response_unpacker.sv
hdl/noc_read_adapter.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/noc_read_adapter_asserts.sv
bench/tb_noc_read_adapter.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_noc_read_adapter -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
